// File: design/ptw_pkg.sv
/*
 * Sv39 page table walker package
 * widths, PTE bit positions, shared types and state encodings
 */
`default_nettype none

package ptw_pkg;

    // ------------------------------------------------
    // address and field widths
    // ------------------------------------------------
    localparam int VLEN           = 39;
    localparam int PLEN           = 56;
    localparam int PPN_W          = 44;
    localparam int PAGE_OFFSET_W  = 12;
    localparam int VPN_PART_W     = 9;
    localparam int PTE_SIZE_LOG2  = 3;
    localparam int ASID_W         = 16;
    localparam int DCACHE_INDEX_W = 12;
    localparam int DCACHE_TAG_W   = 44;

    // ------------------------------------------------
    // PTE flag positions
    // ------------------------------------------------
    localparam int PTE_V_BIT   = 0;
    localparam int PTE_R_BIT   = 1;
    localparam int PTE_W_BIT   = 2;
    localparam int PTE_X_BIT   = 3;
    localparam int PTE_G_BIT   = 5;
    localparam int PTE_A_BIT   = 6;
    localparam int PTE_D_BIT   = 7;
    localparam int PTE_PPN_LSB = 10;

    typedef logic [VLEN-1:0]   vaddr_t;
    typedef logic [PLEN-1:0]   paddr_t;
    typedef logic [PPN_W-1:0]  ppn_t;
    typedef logic [63:0]       pte_t;
    typedef logic [ASID_W-1:0] asid_t;

    // Sv39 has three levels, LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_level_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } walk_state_e;

endpackage

`default_nettype wire

// File: design/ptw_mem_if.sv
/*
 * walker to memory port link
 * request and pointer out, grant and registered response back
 */
`timescale 1ns/1ps
`default_nettype none

interface ptw_mem_if;

    logic            req;
    ptw_pkg::paddr_t pptr;
    logic            gnt;
    // response is already registered by the port
    logic            rvalid;
    ptw_pkg::pte_t   rdata;

    modport walker_mp (
        output req,
        output pptr,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport port_mp (
        input  req,
        input  pptr,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

`default_nettype wire

// File: design/ptw_mem_port.sv
/*
 * walker data cache port
 * forwards req/gnt, raises tag_valid after a grant, registers the response
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_mem_port (
    input  wire logic                                clk_i,
    input  wire logic                                rst_ni,
    ptw_mem_if.port_mp                               mem,
    // data cache side
    output logic                                     data_req_o,
    input  wire logic                                data_gnt_i,
    output logic [ptw_pkg::DCACHE_INDEX_W-1:0]       address_index_o,
    output logic [ptw_pkg::DCACHE_TAG_W-1:0]         address_tag_o,
    output logic                                     tag_valid_o,
    input  wire logic                                data_rvalid_i,
    input  wire ptw_pkg::pte_t                       data_rdata_i
);

    logic          tag_valid_q;
    logic          rvalid_q;
    ptw_pkg::pte_t rdata_q;

    assign data_req_o = mem.req;
    assign mem.gnt    = data_gnt_i;

    // index selects the set, tag is compared one cycle later
    assign address_index_o = mem.pptr[ptw_pkg::DCACHE_INDEX_W-1:0];
    assign address_tag_o   =
        mem.pptr[ptw_pkg::DCACHE_INDEX_W+ptw_pkg::DCACHE_TAG_W-1:ptw_pkg::DCACHE_INDEX_W];

    // ------------------------------------------------
    // registered handshake
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_valid_q <= 1'b0;
            rvalid_q    <= 1'b0;
        end else begin
            tag_valid_q <= mem.req & data_gnt_i;
            rvalid_q    <= data_rvalid_i;
        end
    end

    // response data only matters alongside rvalid
    always_ff @(posedge clk_i) begin
        rdata_q <= data_rdata_i;
    end

    assign tag_valid_o = tag_valid_q;
    assign mem.rvalid  = rvalid_q;
    assign mem.rdata   = rdata_q;

endmodule

`default_nettype wire

// File: design/pte_check.sv
/*
 * PTE checker
 * decodes leaf vs pointer and flags page faults for the current level
 */
`timescale 1ns/1ps
`default_nettype none

module pte_check (
    input  wire ptw_pkg::pte_t       pte_i,
    input  wire ptw_pkg::ptw_level_e level_i,
    input  wire logic                is_instr_i,
    input  wire logic                is_store_i,
    input  wire logic                mxr_i,
    output logic                     leaf_o,
    output logic                     fault_o
);

    logic pte_v;
    logic pte_r;
    logic pte_w;
    logic pte_x;
    logic pte_a;
    logic pte_d;
    logic invalid;
    logic perm_fault;
    logic misaligned;
    logic ptr_at_last;

    assign pte_v = pte_i[ptw_pkg::PTE_V_BIT];
    assign pte_r = pte_i[ptw_pkg::PTE_R_BIT];
    assign pte_w = pte_i[ptw_pkg::PTE_W_BIT];
    assign pte_x = pte_i[ptw_pkg::PTE_X_BIT];
    assign pte_a = pte_i[ptw_pkg::PTE_A_BIT];
    assign pte_d = pte_i[ptw_pkg::PTE_D_BIT];

    // r or x marks a leaf, anything else points one level down
    assign leaf_o = pte_r | pte_x;

    // write-only encodings are reserved
    assign invalid = !pte_v || (pte_w && !pte_r);

    // no further level below LVL3
    assign ptr_at_last = !leaf_o && (level_i == ptw_pkg::LVL3);

    // ------------------------------------------------
    // leaf permissions
    // ------------------------------------------------
    always_comb begin
        if (is_instr_i) begin
            perm_fault = !pte_x || !pte_a;
        end else begin
            // mxr lets loads read execute-only pages
            perm_fault = !pte_a || !(pte_r || (pte_x && mxr_i));
            // a store also needs w and a dirty page
            if (is_store_i && (!pte_w || !pte_d)) begin
                perm_fault = 1'b1;
            end
        end
    end

    // superpages need their low PPN bits clear
    always_comb begin
        case (level_i)
            ptw_pkg::LVL1:
                misaligned = pte_i[ptw_pkg::PTE_PPN_LSB +: 2*ptw_pkg::VPN_PART_W] != '0;
            ptw_pkg::LVL2:
                misaligned = pte_i[ptw_pkg::PTE_PPN_LSB +: ptw_pkg::VPN_PART_W] != '0;
            default:
                misaligned = 1'b0;
        endcase
    end

    assign fault_o = invalid || ptr_at_last || (leaf_o && (perm_fault || misaligned));

endmodule

`default_nettype wire

// File: design/ptw_walker.sv
/*
 * Sv39 walk controller
 * picks a TLB miss, chases pointers level by level and reports
 * either a TLB update or a page fault
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_walker (
    input  wire logic                                       clk_i,
    input  wire logic                                       rst_ni,
    ptw_mem_if.walker_mp                                    mem,
    input  wire ptw_pkg::ppn_t                              satp_ppn_i,
    input  wire ptw_pkg::asid_t                             asid_i,
    // TLB misses
    input  wire logic                                       itlb_access_i,
    input  wire logic                                       itlb_hit_i,
    input  wire ptw_pkg::vaddr_t                            itlb_vaddr_i,
    input  wire logic                                       dtlb_access_i,
    input  wire logic                                       dtlb_hit_i,
    input  wire ptw_pkg::vaddr_t                            dtlb_vaddr_i,
    // PTE checker
    output ptw_pkg::ptw_level_e                             level_o,
    input  wire logic                                       leaf_i,
    input  wire logic                                       fault_i,
    // TLB update
    output logic                                            itlb_update_valid_o,
    output logic                                            dtlb_update_valid_o,
    output logic [ptw_pkg::VLEN-ptw_pkg::PAGE_OFFSET_W-1:0] update_vpn_o,
    output ptw_pkg::asid_t                                  update_asid_o,
    output ptw_pkg::pte_t                                   update_content_o,
    output logic                                            update_is_1g_o,
    output logic                                            update_is_2m_o,
    // status
    output logic                                            ptw_active_o,
    output logic                                            walking_instr_o,
    output logic                                            ptw_error_o,
    output logic                                            itlb_miss_o,
    output logic                                            dtlb_miss_o
);

    ptw_pkg::walk_state_e state_q, state_d;
    ptw_pkg::ptw_level_e  lvl_q, lvl_d;
    logic                 is_instr_q, is_instr_d;
    logic                 global_q, global_d;
    ptw_pkg::vaddr_t      vaddr_q, vaddr_d;
    ptw_pkg::asid_t       asid_q, asid_d;
    ptw_pkg::paddr_t      pptr_q, pptr_d;

    logic                 itlb_take;
    logic                 dtlb_take;
    ptw_pkg::vaddr_t      miss_vaddr;
    logic                 lookup_done;
    logic                 leaf_ok;
    ptw_pkg::ppn_t        pte_ppn;

    // VPN slice idx of a virtual address, idx 2 is the root slice
    function automatic logic [ptw_pkg::VPN_PART_W-1:0] vpn_part(
        input ptw_pkg::vaddr_t va,
        input int unsigned     idx
    );
        return va[ptw_pkg::PAGE_OFFSET_W + idx*ptw_pkg::VPN_PART_W +: ptw_pkg::VPN_PART_W];
    endfunction

    // ------------------------------------------------
    // miss selection, ITLB only when no data access
    // ------------------------------------------------
    assign itlb_take  = itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
    assign dtlb_take  = dtlb_access_i & ~dtlb_hit_i;
    assign miss_vaddr = itlb_take ? itlb_vaddr_i : dtlb_vaddr_i;

    assign itlb_miss_o = (state_q == ptw_pkg::IDLE) & itlb_take;
    assign dtlb_miss_o = (state_q == ptw_pkg::IDLE) & dtlb_take;

    assign lookup_done = (state_q == ptw_pkg::PTE_LOOKUP) & mem.rvalid;
    assign leaf_ok     = lookup_done & leaf_i & ~fault_i;
    assign pte_ppn     = mem.rdata[ptw_pkg::PTE_PPN_LSB +: ptw_pkg::PPN_W];

    // ------------------------------------------------
    // next state
    // ------------------------------------------------
    always_comb begin
        state_d    = state_q;
        lvl_d      = lvl_q;
        is_instr_d = is_instr_q;
        global_d   = global_q;
        vaddr_d    = vaddr_q;
        asid_d     = asid_q;
        pptr_d     = pptr_q;

        case (state_q)
            ptw_pkg::IDLE: begin
                lvl_d    = ptw_pkg::LVL1;
                global_d = 1'b0;
                if (itlb_take || dtlb_take) begin
                    is_instr_d = itlb_take;
                    vaddr_d    = miss_vaddr;
                    asid_d     = asid_i;
                    // root table from satp, indexed by VPN[2]
                    pptr_d     = {satp_ppn_i, vpn_part(miss_vaddr, 2),
                                  {ptw_pkg::PTE_SIZE_LOG2{1'b0}}};
                    state_d    = ptw_pkg::WAIT_GRANT;
                end
            end

            ptw_pkg::WAIT_GRANT: begin
                if (mem.gnt) begin
                    state_d = ptw_pkg::PTE_LOOKUP;
                end
            end

            ptw_pkg::PTE_LOOKUP: begin
                if (mem.rvalid) begin
                    global_d = global_q | mem.rdata[ptw_pkg::PTE_G_BIT];
                    if (fault_i) begin
                        state_d = ptw_pkg::PROPAGATE_ERROR;
                    end else if (leaf_i) begin
                        state_d = ptw_pkg::IDLE;
                    end else begin
                        // pointer, descend one level
                        lvl_d   = (lvl_q == ptw_pkg::LVL1) ? ptw_pkg::LVL2 : ptw_pkg::LVL3;
                        pptr_d  = {pte_ppn,
                                   vpn_part(vaddr_q, (lvl_q == ptw_pkg::LVL1) ? 1 : 0),
                                   {ptw_pkg::PTE_SIZE_LOG2{1'b0}}};
                        state_d = ptw_pkg::WAIT_GRANT;
                    end
                end
            end

            default: begin
                state_d = ptw_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ptw_pkg::IDLE;
            lvl_q      <= ptw_pkg::LVL1;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            global_q   <= global_d;
        end
    end

    // latched miss context
    always_ff @(posedge clk_i) begin
        vaddr_q <= vaddr_d;
        asid_q  <= asid_d;
        pptr_q  <= pptr_d;
    end

    // ------------------------------------------------
    // outputs
    // ------------------------------------------------
    assign mem.req  = (state_q == ptw_pkg::WAIT_GRANT);
    assign mem.pptr = pptr_q;
    assign level_o  = lvl_q;

    assign ptw_active_o    = (state_q != ptw_pkg::IDLE);
    assign walking_instr_o = is_instr_q;
    assign ptw_error_o     = (state_q == ptw_pkg::PROPAGATE_ERROR);

    assign itlb_update_valid_o = leaf_ok & is_instr_q;
    assign dtlb_update_valid_o = leaf_ok & ~is_instr_q;
    assign update_vpn_o        = vaddr_q[ptw_pkg::VLEN-1:ptw_pkg::PAGE_OFFSET_W];
    assign update_asid_o       = asid_q;
    assign update_is_1g_o      = (lvl_q == ptw_pkg::LVL1);
    assign update_is_2m_o      = (lvl_q == ptw_pkg::LVL2);
    // G from any level of the walk makes the whole mapping global
    assign update_content_o    = mem.rdata | (ptw_pkg::pte_t'(global_q) << ptw_pkg::PTE_G_BIT);

endmodule

`default_nettype wire

// File: design/ptw_top.sv
/*
 * Sv39 hardware page table walker
 * serves ITLB and DTLB misses through a req/gnt/rvalid data cache port
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_top (
    input  wire logic                                       clk_i,
    input  wire logic                                       rst_ni,
    // CSR and LSU state
    input  wire logic                                       mxr_i,
    input  wire ptw_pkg::ppn_t                              satp_ppn_i,
    input  wire ptw_pkg::asid_t                             asid_i,
    input  wire logic                                       lsu_is_store_i,
    // ITLB
    input  wire logic                                       itlb_access_i,
    input  wire logic                                       itlb_hit_i,
    input  wire ptw_pkg::vaddr_t                            itlb_vaddr_i,
    // DTLB
    input  wire logic                                       dtlb_access_i,
    input  wire logic                                       dtlb_hit_i,
    input  wire ptw_pkg::vaddr_t                            dtlb_vaddr_i,
    // data cache
    output logic                                            data_req_o,
    input  wire logic                                       data_gnt_i,
    output logic [ptw_pkg::DCACHE_INDEX_W-1:0]              address_index_o,
    output logic [ptw_pkg::DCACHE_TAG_W-1:0]                address_tag_o,
    output logic                                            tag_valid_o,
    input  wire logic                                       data_rvalid_i,
    input  wire ptw_pkg::pte_t                              data_rdata_i,
    // TLB update
    output logic                                            itlb_update_valid_o,
    output logic                                            dtlb_update_valid_o,
    output logic [ptw_pkg::VLEN-ptw_pkg::PAGE_OFFSET_W-1:0] update_vpn_o,
    output ptw_pkg::asid_t                                  update_asid_o,
    output ptw_pkg::pte_t                                   update_content_o,
    output logic                                            update_is_1g_o,
    output logic                                            update_is_2m_o,
    // status and perf counters
    output logic                                            ptw_active_o,
    output logic                                            walking_instr_o,
    output logic                                            ptw_error_o,
    output logic                                            itlb_miss_o,
    output logic                                            dtlb_miss_o
);

    ptw_mem_if           mem_bus ();
    ptw_pkg::ptw_level_e level;
    logic                leaf;
    logic                fault;

    ptw_walker u_walker (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .mem                 (mem_bus.walker_mp),
        .satp_ppn_i          (satp_ppn_i),
        .asid_i              (asid_i),
        .itlb_access_i       (itlb_access_i),
        .itlb_hit_i          (itlb_hit_i),
        .itlb_vaddr_i        (itlb_vaddr_i),
        .dtlb_access_i       (dtlb_access_i),
        .dtlb_hit_i          (dtlb_hit_i),
        .dtlb_vaddr_i        (dtlb_vaddr_i),
        .level_o             (level),
        .leaf_i              (leaf),
        .fault_i             (fault),
        .itlb_update_valid_o (itlb_update_valid_o),
        .dtlb_update_valid_o (dtlb_update_valid_o),
        .update_vpn_o        (update_vpn_o),
        .update_asid_o       (update_asid_o),
        .update_content_o    (update_content_o),
        .update_is_1g_o      (update_is_1g_o),
        .update_is_2m_o      (update_is_2m_o),
        .ptw_active_o        (ptw_active_o),
        .walking_instr_o     (walking_instr_o),
        .ptw_error_o         (ptw_error_o),
        .itlb_miss_o         (itlb_miss_o),
        .dtlb_miss_o         (dtlb_miss_o)
    );

    // checks the registered PTE against the level being walked
    pte_check u_pte_check (
        .pte_i      (mem_bus.rdata),
        .level_i    (level),
        .is_instr_i (walking_instr_o),
        .is_store_i (lsu_is_store_i),
        .mxr_i      (mxr_i),
        .leaf_o     (leaf),
        .fault_o    (fault)
    );

    ptw_mem_port u_mem_port (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .mem             (mem_bus.port_mp),
        .data_req_o      (data_req_o),
        .data_gnt_i      (data_gnt_i),
        .address_index_o (address_index_o),
        .address_tag_o   (address_tag_o),
        .tag_valid_o     (tag_valid_o),
        .data_rvalid_i   (data_rvalid_i),
        .data_rdata_i    (data_rdata_i)
    );

endmodule

`default_nettype wire

// File: tests/tb_ptw.sv
/*
 * testbench for the Sv39 page table walker
 * replays walks from a data file against a cache model with random stalls
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ptw;

    localparam int          CLK_PERIOD = 40;
    localparam int          MAX_TESTS  = 32;
    localparam int          WALK_LIMIT = 60;
    localparam logic [31:0] SEED       = 32'h913f414c;
    localparam string       INPUT_FILE = "tests/ptw_input.txt";

    logic                   clk_i;
    logic                   rst_ni;
    logic                   mxr_i;
    ptw_pkg::ppn_t          satp_ppn_i;
    ptw_pkg::asid_t         asid_i;
    logic                   lsu_is_store_i;
    logic                   itlb_access_i;
    logic                   itlb_hit_i;
    ptw_pkg::vaddr_t        itlb_vaddr_i;
    logic                   dtlb_access_i;
    logic                   dtlb_hit_i;
    ptw_pkg::vaddr_t        dtlb_vaddr_i;
    logic                   data_req_o;
    logic                   data_gnt_i;
    logic [11:0]            address_index_o;
    logic [43:0]            address_tag_o;
    logic                   tag_valid_o;
    logic                   data_rvalid_i;
    ptw_pkg::pte_t          data_rdata_i;
    logic                   itlb_update_valid_o;
    logic                   dtlb_update_valid_o;
    logic [26:0]            update_vpn_o;
    ptw_pkg::asid_t         update_asid_o;
    ptw_pkg::pte_t          update_content_o;
    logic                   update_is_1g_o;
    logic                   update_is_2m_o;
    logic                   ptw_active_o;
    logic                   walking_instr_o;
    logic                   ptw_error_o;
    logic                   itlb_miss_o;
    logic                   dtlb_miss_o;

    // test table loaded from the data file
    string                  t_name    [MAX_TESTS];
    string                  t_kind    [MAX_TESTS];
    logic                   t_store   [MAX_TESTS];
    logic                   t_mxr     [MAX_TESTS];
    ptw_pkg::ppn_t          t_satp    [MAX_TESTS];
    ptw_pkg::vaddr_t        t_vaddr   [MAX_TESTS];
    ptw_pkg::asid_t         t_asid    [MAX_TESTS];
    ptw_pkg::pte_t          t_pte     [MAX_TESTS][3];
    string                  t_outcome [MAX_TESTS];
    ptw_pkg::pte_t          t_content [MAX_TESTS];
    logic [1:0]             t_size    [MAX_TESTS];

    int                     num_tests;
    int                     err_count;
    int                     passed;
    int                     cur;
    logic                   walk_done;

    ptw_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD/2) clk_i = ~clk_i;
        end
    end

    task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("ERROR %0s %0s: expected %h actual %h", t_name[cur], what, exp, act);
            err_count++;
        end
    endtask

    // --------------------------------------------------
    // data file
    // --------------------------------------------------
    task automatic load_tests();
        int          fd;
        int          n_fields;
        string       line;
        string       name;
        string       kind;
        string       outcome;
        int          store_v;
        int          mxr_v;
        logic [63:0] satp_v;
        logic [63:0] vaddr_v;
        logic [63:0] asid_v;
        logic [63:0] p0;
        logic [63:0] p1;
        logic [63:0] p2;
        logic [63:0] content_v;
        logic [1:0]  size_v;
        num_tests = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test file %0s", INPUT_FILE);
            err_count++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%s %s %d %d %h %h %h %h %h %h %s %h %b",
                               name, kind, store_v, mxr_v, satp_v, vaddr_v, asid_v,
                               p0, p1, p2, outcome, content_v, size_v);
            if (n_fields != 13) begin
                $display("skipping a malformed line in the test file: %0s", line);
                err_count++;
            end else begin
                t_name[num_tests]    = name;
                t_kind[num_tests]    = kind;
                t_store[num_tests]   = store_v[0];
                t_mxr[num_tests]     = mxr_v[0];
                t_satp[num_tests]    = satp_v[43:0];
                t_vaddr[num_tests]   = vaddr_v[38:0];
                t_asid[num_tests]    = asid_v[15:0];
                t_pte[num_tests][0]  = p0;
                t_pte[num_tests][1]  = p1;
                t_pte[num_tests][2]  = p2;
                t_outcome[num_tests] = outcome;
                t_content[num_tests] = content_v;
                t_size[num_tests]    = size_v;
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    // table base is satp for the root and the previous PTE's PPN below it
    function automatic ptw_pkg::paddr_t expected_ptr(int idx);
        ptw_pkg::ppn_t ppn;
        logic [8:0]    slice;
        if (idx == 0) begin
            ppn = t_satp[cur];
        end else begin
            ppn = t_pte[cur][idx-1][53:10];
        end
        slice = t_vaddr[cur][12 + 9*(2-idx) +: 9];
        return {ppn, slice, 3'b000};
    endfunction

    // --------------------------------------------------
    // cache model serving one request per call
    // --------------------------------------------------
    task automatic serve_request(inout int req_idx);
        ptw_pkg::paddr_t addr;
        ptw_pkg::pte_t   pte;
        int              stall;
        int              delay;
        addr = {address_tag_o, address_index_o};
        pte  = '0;
        if (req_idx < 3) begin
            check_value($sformatf("request %0d address", req_idx),
                        64'(expected_ptr(req_idx)), 64'(addr));
            pte = t_pte[cur][req_idx];
        end else begin
            $display("test %0s: walker issued more than three requests", t_name[cur]);
            err_count++;
        end
        stall = $urandom_range(3, 0);
        repeat (stall) begin
            @(negedge clk_i);
            check_value("req held in stall", 64'd1, 64'(data_req_o));
            check_value("address held in stall", 64'(addr),
                        64'({address_tag_o, address_index_o}));
            check_value("tag_valid in stall", 64'd0, 64'(tag_valid_o));
        end
        @(posedge clk_i);
        data_gnt_i <= 1'b1;
        @(posedge clk_i);
        data_gnt_i <= 1'b0;
        @(negedge clk_i);
        check_value("tag_valid after grant", 64'd1, 64'(tag_valid_o));
        delay = $urandom_range(3, 1);
        repeat (delay) begin
            @(posedge clk_i);
        end
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= pte;
        @(negedge clk_i);
        check_value("tag_valid single cycle", 64'd0, 64'(tag_valid_o));
        @(posedge clk_i);
        data_rvalid_i <= 1'b0;
        data_rdata_i  <= '0;
        req_idx++;
    endtask

    task automatic check_outcome(logic is_instr);
        if (t_outcome[cur] == "update") begin
            check_value("itlb update valid", 64'(is_instr), 64'(itlb_update_valid_o));
            check_value("dtlb update valid", 64'(!is_instr), 64'(dtlb_update_valid_o));
            check_value("content", t_content[cur], update_content_o);
            check_value("asid", 64'(t_asid[cur]), 64'(update_asid_o));
            check_value("vpn", 64'(t_vaddr[cur][38:12]), 64'(update_vpn_o));
            check_value("size 1g/2m", 64'(t_size[cur]),
                        64'({update_is_1g_o, update_is_2m_o}));
        end else begin
            check_value("ptw_error", 64'd1, 64'(ptw_error_o));
            check_value("update valids", 64'd0,
                        64'({itlb_update_valid_o, dtlb_update_valid_o}));
        end
    endtask

    // --------------------------------------------------
    // one walk drives the miss, serves memory and watches the result
    // --------------------------------------------------
    task automatic run_test(int idx);
        int   errs_before;
        int   req_idx;
        int   cycles;
        int   itlb_pulses;
        int   dtlb_pulses;
        logic is_instr;
        cur         = idx;
        errs_before = err_count;
        is_instr    = (t_kind[idx] == "I");
        walk_done   = 1'b0;
        req_idx     = 0;
        cycles      = 0;
        itlb_pulses = 0;
        dtlb_pulses = 0;
        @(posedge clk_i);
        mxr_i          <= t_mxr[idx];
        satp_ppn_i     <= t_satp[idx];
        asid_i         <= t_asid[idx];
        lsu_is_store_i <= t_store[idx];
        if (is_instr) begin
            itlb_access_i <= 1'b1;
            itlb_vaddr_i  <= t_vaddr[idx];
        end else begin
            dtlb_access_i <= 1'b1;
            dtlb_vaddr_i  <= t_vaddr[idx];
            // simultaneous ITLB miss on an unrelated page
            if (t_kind[idx] == "B") begin
                itlb_access_i <= 1'b1;
                itlb_vaddr_i  <= ~t_vaddr[idx];
            end
        end
        fork
            begin
                while (!walk_done) begin
                    @(negedge clk_i);
                    if (data_req_o && !walk_done) begin
                        serve_request(req_idx);
                    end
                end
            end
            begin
                while (!walk_done) begin
                    @(negedge clk_i);
                    itlb_pulses += int'(itlb_miss_o);
                    dtlb_pulses += int'(dtlb_miss_o);
                    if (ptw_active_o) begin
                        check_value("walking_instr", 64'(is_instr), 64'(walking_instr_o));
                    end
                    cycles++;
                    if (itlb_update_valid_o || dtlb_update_valid_o || ptw_error_o) begin
                        check_outcome(is_instr);
                        walk_done = 1'b1;
                    end else if (cycles >= WALK_LIMIT) begin
                        $display("test %0s: no update and no error after %0d cycles",
                                 t_name[idx], WALK_LIMIT);
                        err_count++;
                        walk_done = 1'b1;
                    end
                end
                // TLB releases its miss once it has an answer
                @(posedge clk_i);
                itlb_access_i <= 1'b0;
                dtlb_access_i <= 1'b0;
                @(negedge clk_i);
                check_value("back to idle", 64'd0, 64'(ptw_active_o));
            end
        join
        check_value("itlb miss pulses", 64'(is_instr), 64'(itlb_pulses));
        check_value("dtlb miss pulses", 64'(!is_instr), 64'(dtlb_pulses));
        if (err_count == errs_before) begin
            passed++;
            $display("test %0s: ok", t_name[idx]);
        end else begin
            $display("test %0s: failed with %0d bad checks", t_name[idx],
                     err_count - errs_before);
        end
    endtask

    initial begin
        err_count      = 0;
        passed         = 0;
        cur            = 0;
        walk_done      = 1'b0;
        rst_ni         = 1'b0;
        mxr_i          = 1'b0;
        satp_ppn_i     = '0;
        asid_i         = '0;
        lsu_is_store_i = 1'b0;
        itlb_access_i  = 1'b0;
        itlb_hit_i     = 1'b0;
        itlb_vaddr_i   = '0;
        dtlb_access_i  = 1'b0;
        dtlb_hit_i     = 1'b0;
        dtlb_vaddr_i   = '0;
        data_gnt_i     = 1'b0;
        data_rvalid_i  = 1'b0;
        data_rdata_i   = '0;
        void'($urandom(SEED));
        load_tests();
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        $display("tests %0d, passed %0d, failed %0d, bad checks %0d",
                 num_tests, passed, num_tests - passed, err_count);
        if (err_count == 0 && num_tests > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog allows 40 cycles per walk plus reset and margin
    initial begin
        int limit;
        #(CLK_PERIOD);
        limit = (num_tests + 1) * 40 + 20;
        repeat (limit) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/ptw_input.txt
# name kind(I/D/B) store mxr satp_ppn vaddr asid pte0 pte1 pte2 outcome content size(1g,2m)
# PTE words are returned in request order, unused words are 0
data_4k_store        D 1 0 80000 40403abc   0011 20000401 20000801 20048cc7 update 20048cc7 00
instr_1g             I 0 0 80000 80001234   0022 1000004b 0        0        update 1000004b 10
instr_2m             I 0 0 80000 40a00010   0033 20001001 20080049 0        update 20080049 01
global_from_root     D 0 0 80000 40403000   0044 20000421 20000801 20048cc3 update 20048ce3 00
fault_invalid        D 0 0 80000 40403000   0055 20000400 0        0        error  0        00
fault_w_without_r    D 0 0 80000 40403000   0055 20000401 20000805 0        error  0        00
fault_no_exec        I 0 0 80000 40403000   0066 20000401 20000801 20048c43 error  0        00
fault_no_access      D 0 0 80000 40403000   0066 20000401 20000801 20048c83 error  0        00
fault_store_clean    D 1 0 80000 40403000   0077 20000401 20000801 20048c47 error  0        00
fault_ptr_at_lvl3    D 0 0 80000 40403000   0077 20000401 20000801 20048c01 error  0        00
fault_misaligned_1g  D 0 0 80000 80001234   0088 100004c3 0        0        error  0        00
fault_misaligned_2m  D 0 0 80000 40a00010   0088 20001001 200804c3 0        error  0        00
mxr_exec_only        D 0 1 80000 40403000   0099 20000401 20000801 20048c49 update 20048c49 00
no_mxr_exec_only     D 0 0 80000 40403000   0099 20000401 20000801 20048c49 error  0        00
both_miss_dtlb_first B 0 0 80000 40403000   00aa 20000401 20000801 20048cc3 update 20048cc3 00
data_2m              D 0 0 80000 40a12345   00bb 20000401 200800c3 0        update 200800c3 01
instr_4k             I 0 0 80000 7fc0201000 00cc 20000401 20000801 20048c4b update 20048c4b 00
data_1g              D 0 0 80000 c0000000   00dd 200000c3 0        0        update 200000c3 10

// File: filelist.f
design/ptw_pkg.sv
design/ptw_mem_if.sv
design/ptw_mem_port.sv
design/pte_check.sv
design/ptw_walker.sv
design/ptw_top.sv
tests/tb_ptw.sv

// File: run.sh
#!/bin/sh
# build and run the page table walker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --top-module tb_ptw -f filelist.f -o tb_ptw \
    && ./obj_dir/tb_ptw; } > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
